//--- src/step_pkg.sv
package step_pkg;

    // ------------------------------------------------------------------
    // widths that carry a meaning
    // ------------------------------------------------------------------

    // |dynamic accel| after preprocessing, in raw sensor lsbs
    typedef logic [15:0] mag_t;

    // strobed samples, used for peak length and gap since last step
    // counters of this type saturate at all ones
    typedef logic [15:0] sample_count_t;

    // raw clock cycles, saturating
    // 32 bits covers several seconds at typical fabric clocks
    typedef logic [31:0] cycle_count_t;

    // running step total, wraps around
    typedef logic [15:0] step_count_t;

    // ------------------------------------------------------------------
    // peak state machine
    // ------------------------------------------------------------------

    // idle       waiting for a sample at or above the high threshold
    // peak_rise  inside a peak, counting samples at or above the low one
    // peak_fall  single cycle, peak just ended and its length is frozen
    typedef enum logic [1:0] {
        idle,
        peak_rise,
        peak_fall
    } peak_state_t;

    // finished peak as seen by the qualifier
    // ended is a one-cycle flag, len is only meaningful while it is high
    typedef struct packed {
        logic          ended;
        sample_count_t len;
    } peak_event_t;

endpackage

//--- src/peak_tracker.sv
module peak_tracker #(
    parameter step_pkg::mag_t        th_high          = 16'd250,
    parameter step_pkg::mag_t        th_low           = 16'd150,
    parameter step_pkg::sample_count_t max_peak_samples = 16'd200
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    dyn_valid,
    input  step_pkg::mag_t          z_dynamic_abs,
    input  logic                    armed,
    output step_pkg::peak_event_t   peak_event,
    output logic                    in_peak,
    output step_pkg::sample_count_t peak_len
);

    import step_pkg::*;

    peak_state_t   state;
    peak_state_t   state_next;
    sample_count_t len_q;

    // qualified sample conditions, all gated by the strobe
    logic sample_high;
    logic sample_keep;
    logic sample_drop;
    logic len_at_max;

    assign sample_high = dyn_valid && (z_dynamic_abs >= th_high);
    assign sample_keep = dyn_valid && (z_dynamic_abs >= th_low);
    assign sample_drop = dyn_valid && (z_dynamic_abs < th_low);

    // peak already as long as allowed
    assign len_at_max  = (len_q >= max_peak_samples);

    // ------------------------------------------------------------------
    // next-state logic
    // ------------------------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                // new peak only once the cooldown has re-armed us
                if (sample_high && armed) begin
                    state_next = peak_rise;
                end
            end
            peak_rise: begin
                if (sample_drop) begin
                    state_next = peak_fall;
                end else if (sample_keep && len_at_max) begin
                    // too long to be a step, drop it silently
                    state_next = idle;
                end
            end
            peak_fall: begin
                // event shown for exactly one cycle
                state_next = idle;
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    // ------------------------------------------------------------------
    // state register and peak length counter
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= idle;
            len_q <= '0;
        end else begin
            state <= state_next;
            case (state)
                idle: begin
                    // first sample of the peak counts
                    if (sample_high && armed) begin
                        len_q <= sample_count_t'(1);
                    end
                end
                peak_rise: begin
                    if (sample_keep) begin
                        if (len_at_max) begin
                            len_q <= '0;
                        end else if (len_q != '1) begin
                            len_q <= len_q + sample_count_t'(1);
                        end
                    end
                    // below th_low the length stays frozen for peak_fall
                end
                default: begin
                    len_q <= '0;
                end
            endcase
        end
    end

    // outputs follow the state directly
    assign in_peak          = (state == peak_rise) || (state == peak_fall);
    assign peak_len         = len_q;
    assign peak_event.ended = (state == peak_fall);
    assign peak_event.len   = len_q;

endmodule

//--- src/gap_timer.sv
module gap_timer #(
    parameter step_pkg::sample_count_t min_step_gap_samples = 16'd200,
    parameter step_pkg::cycle_count_t  min_step_gap_cycles  = 32'd50_000_000
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    dyn_valid,
    input  logic                    step_accept,
    output step_pkg::sample_count_t gap_samples,
    output logic                    armed
);

    import step_pkg::*;

    sample_count_t samples_q;
    cycle_count_t  cycles_q;
    logic          armed_q;

    // both cooldown measures have elapsed
    logic gap_done;

    assign gap_done = (samples_q >= min_step_gap_samples) &&
                      (cycles_q >= min_step_gap_cycles);

    // ------------------------------------------------------------------
    // gap counters since last accepted step
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            samples_q <= '0;
            cycles_q  <= '0;
        end else if (step_accept) begin
            // restart the refractory window
            samples_q <= '0;
            cycles_q  <= '0;
        end else begin
            // cycles count every clock, saturating
            if (cycles_q != '1) begin
                cycles_q <= cycles_q + cycle_count_t'(1);
            end
            // samples count strobes only, saturating
            if (dyn_valid && (samples_q != '1)) begin
                samples_q <= samples_q + sample_count_t'(1);
            end
        end
    end

    // ------------------------------------------------------------------
    // arming flag
    // ------------------------------------------------------------------
    // set out of reset, so the very first peak needs no cooldown
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            armed_q <= 1'b1;
        end else if (step_accept) begin
            armed_q <= 1'b0;
        end else if (gap_done) begin
            armed_q <= 1'b1;
        end
    end

    assign gap_samples = samples_q;
    assign armed       = armed_q;

endmodule

//--- src/step_qualifier.sv
module step_qualifier #(
    parameter step_pkg::sample_count_t min_peak_samples = 16'd8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  step_pkg::peak_event_t peak_event,
    output logic                  step_accept,
    output logic                  step_pulse,
    output step_pkg::step_count_t step_count
);

    import step_pkg::*;

    logic        pulse_q;
    step_count_t count_q;

    // long peaks never reach here, the tracker abandons them
    // so only the lower bound is judged
    assign step_accept = peak_event.ended && (peak_event.len >= min_peak_samples);

    // ------------------------------------------------------------------
    // step pulse and running count
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pulse_q <= 1'b0;
            count_q <= '0;
        end else begin
            // one cycle after ended, i.e. on the edge leaving peak_fall
            pulse_q <= step_accept;
            if (step_accept) begin
                // wraps on overflow
                count_q <= count_q + step_count_t'(1);
            end
        end
    end

    assign step_pulse = pulse_q;
    assign step_count = count_q;

endmodule

//--- src/step_detector.sv
module step_detector #(
    parameter step_pkg::mag_t          th_high              = 16'd250,
    parameter step_pkg::mag_t          th_low               = 16'd150,
    parameter step_pkg::sample_count_t min_peak_samples     = 16'd8,
    parameter step_pkg::sample_count_t max_peak_samples     = 16'd200,
    parameter step_pkg::sample_count_t min_step_gap_samples = 16'd200,
    parameter step_pkg::cycle_count_t  min_step_gap_cycles  = 32'd50_000_000
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    dyn_valid,
    input  step_pkg::mag_t          z_dynamic_abs,
    output logic                    step_pulse,
    output step_pkg::step_count_t   step_count,
    output logic                    in_peak,
    output step_pkg::sample_count_t peak_len_samples,
    output step_pkg::sample_count_t gap_samples
);

    import step_pkg::*;

    // tracker to qualifier
    peak_event_t peak_event;
    // qualifier to gap timer
    logic        step_accept;
    // gap timer back to tracker
    logic        armed;

    // ------------------------------------------------------------------
    // peak detection and cooldown side by side
    // ------------------------------------------------------------------
    peak_tracker #(
        .th_high          (th_high),
        .th_low           (th_low),
        .max_peak_samples (max_peak_samples)
    ) peak_tracker_inst (
        .clk           (clk),
        .reset         (reset),
        .dyn_valid     (dyn_valid),
        .z_dynamic_abs (z_dynamic_abs),
        .armed         (armed),
        .peak_event    (peak_event),
        .in_peak       (in_peak),
        .peak_len      (peak_len_samples)
    );

    gap_timer #(
        .min_step_gap_samples (min_step_gap_samples),
        .min_step_gap_cycles  (min_step_gap_cycles)
    ) gap_timer_inst (
        .clk         (clk),
        .reset       (reset),
        .dyn_valid   (dyn_valid),
        .step_accept (step_accept),
        .gap_samples (gap_samples),
        .armed       (armed)
    );

    // judges finished peaks, closes the loop through step_accept
    step_qualifier #(
        .min_peak_samples (min_peak_samples)
    ) step_qualifier_inst (
        .clk         (clk),
        .reset       (reset),
        .peak_event  (peak_event),
        .step_accept (step_accept),
        .step_pulse  (step_pulse),
        .step_count  (step_count)
    );

endmodule

//--- test/step_detector_sva.sv
module step_detector_sva #(
    parameter step_pkg::mag_t          th_low               = 16'd150,
    parameter step_pkg::sample_count_t min_peak_samples     = 16'd8,
    parameter step_pkg::sample_count_t max_peak_samples     = 16'd200,
    parameter step_pkg::sample_count_t min_step_gap_samples = 16'd200,
    parameter step_pkg::cycle_count_t  min_step_gap_cycles  = 32'd50_000_000
) (
    input logic                    clk,
    input logic                    reset,
    input logic                    dyn_valid,
    input step_pkg::mag_t          z_dynamic_abs,
    input logic                    step_pulse,
    input step_pkg::step_count_t   step_count,
    input logic                    in_peak,
    input step_pkg::sample_count_t peak_len_samples,
    input step_pkg::sample_count_t gap_samples
);

    import step_pkg::*;

    // each assertion sets its own sticky flag when it fails
    logic bad_reset = 1'b0;
    logic bad_cause = 1'b0;
    logic bad_pulse = 1'b0;
    logic bad_double = 1'b0;
    logic bad_count = 1'b0;
    logic bad_len = 1'b0;
    logic bad_long = 1'b0;
    logic bad_gap = 1'b0;
    logic bad_cool = 1'b0;
    logic any_failed;

    // high in the single cycle right after a peak ended (peak_fall)
    logic          fall_cycle;
    logic          peak_drop;
    logic          step_cause;
    logic          long_keep;
    cycle_count_t  cyc_since;
    sample_count_t str_since;

    assign any_failed = bad_reset | bad_cause | bad_pulse | bad_double | bad_count |
                        bad_len | bad_long | bad_gap | bad_cool;

    // strobed drop below th_low while the peak is still rising
    assign peak_drop  = dyn_valid && (z_dynamic_abs < th_low) && in_peak && !fall_cycle;
    assign step_cause = peak_drop && (peak_len_samples >= min_peak_samples);
    // another keep sample on a peak already at full length
    assign long_keep  = dyn_valid && (z_dynamic_abs >= th_low) && in_peak && !fall_cycle &&
                        (peak_len_samples == max_peak_samples);

    // ------------------------------------------------------------------
    // cycles and strobes since the last step pulse
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fall_cycle <= 1'b0;
            // saturated so the first peak is never in cooldown
            cyc_since  <= '1;
            str_since  <= '1;
        end else begin
            fall_cycle <= peak_drop;
            if (step_pulse) begin
                cyc_since <= '0;
                str_since <= sample_count_t'(dyn_valid);
            end else begin
                if (cyc_since != '1) begin
                    cyc_since <= cyc_since + cycle_count_t'(1);
                end
                if (dyn_valid && (str_since != '1)) begin
                    str_since <= str_since + sample_count_t'(1);
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // properties on the top-level ports
    // ------------------------------------------------------------------
    reset_values: assert property (@(posedge clk)
        reset |-> (!step_pulse && !in_peak && (step_count == '0) &&
                   (peak_len_samples == '0) && (gap_samples == '0)))
        else begin
            bad_reset = 1'b1;
            $error("outputs not cleared in reset");
        end

    // long enough peak ending below th_low gives a pulse two edges later
    cause_to_pulse: assert property (@(posedge clk) disable iff (reset)
        step_cause |-> ##2 step_pulse)
        else begin
            bad_cause = 1'b1;
            $error("qualified peak end gave no step_pulse");
        end

    pulse_from_cause: assert property (@(posedge clk) disable iff (reset)
        step_pulse |-> $past(step_cause, 2))
        else begin
            bad_pulse = 1'b1;
            $error("step_pulse without a qualified peak end");
        end

    single_pulse: assert property (@(posedge clk) disable iff (reset)
        step_pulse |=> !step_pulse)
        else begin
            bad_double = 1'b1;
            $error("step_pulse high on two cycles");
        end

    count_tracks_pulse: assert property (@(posedge clk) disable iff (reset)
        step_count == (step_pulse ? $past(step_count) + step_count_t'(1) :
                                    $past(step_count)))
        else begin
            bad_count = 1'b1;
            $error("step_count out of step with step_pulse");
        end

    len_bounded: assert property (@(posedge clk) disable iff (reset)
        peak_len_samples <= max_peak_samples)
        else begin
            bad_len = 1'b1;
            $error("peak_len_samples above maximum");
        end

    // over-long peak is dropped and never becomes a step
    long_abandoned: assert property (@(posedge clk) disable iff (reset)
        long_keep |=> !in_peak ##1 !step_pulse)
        else begin
            bad_long = 1'b1;
            $error("over-long peak not abandoned");
        end

    gap_cleared: assert property (@(posedge clk) disable iff (reset)
        step_pulse |-> (gap_samples == '0))
        else begin
            bad_gap = 1'b1;
            $error("gap_samples not cleared by step");
        end

    cooldown_respected: assert property (@(posedge clk) disable iff (reset)
        $rose(in_peak) |-> ((cyc_since >= min_step_gap_cycles) &&
                            (str_since >= min_step_gap_samples)))
        else begin
            bad_cool = 1'b1;
            $error("peak started inside the cooldown");
        end

endmodule

bind step_detector step_detector_sva #(
    .th_low               (th_low),
    .min_peak_samples     (min_peak_samples),
    .max_peak_samples     (max_peak_samples),
    .min_step_gap_samples (min_step_gap_samples),
    .min_step_gap_cycles  (min_step_gap_cycles)
) step_detector_sva_inst (
    .clk              (clk),
    .reset            (reset),
    .dyn_valid        (dyn_valid),
    .z_dynamic_abs    (z_dynamic_abs),
    .step_pulse       (step_pulse),
    .step_count       (step_count),
    .in_peak          (in_peak),
    .peak_len_samples (peak_len_samples),
    .gap_samples      (gap_samples)
);

//--- test/step_detector_tb.sv
module step_detector_tb;

    import step_pkg::*;

    // small values so cooldown and long peaks show up quickly
    localparam mag_t          th_high              = 16'd250;
    localparam mag_t          th_low               = 16'd150;
    localparam sample_count_t min_peak_samples     = 16'd4;
    localparam sample_count_t max_peak_samples     = 16'd12;
    localparam sample_count_t min_step_gap_samples = 16'd6;
    localparam cycle_count_t  min_step_gap_cycles  = 32'd80;

    logic          clk;
    logic          reset;
    logic          dyn_valid;
    mag_t          z_dynamic_abs;
    logic          step_pulse;
    step_count_t   step_count;
    logic          in_peak;
    sample_count_t peak_len_samples;
    sample_count_t gap_samples;

    int unsigned   cycle_count = 0;
    step_count_t   expected_steps;
    // set after an accepted step while the detector still cools down
    logic          cooling;

    step_detector #(
        .th_high              (th_high),
        .th_low               (th_low),
        .min_peak_samples     (min_peak_samples),
        .max_peak_samples     (max_peak_samples),
        .min_step_gap_samples (min_step_gap_samples),
        .min_step_gap_cycles  (min_step_gap_cycles)
    ) step_detector_inst (
        .clk              (clk),
        .reset            (reset),
        .dyn_valid        (dyn_valid),
        .z_dynamic_abs    (z_dynamic_abs),
        .step_pulse       (step_pulse),
        .step_count       (step_count),
        .in_peak          (in_peak),
        .peak_len_samples (peak_len_samples),
        .gap_samples      (gap_samples)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    task automatic stop_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on failure");
    endtask

    function automatic mag_t rand_mag(input int lo, input int hi);
        return mag_t'($urandom_range(hi, lo));
    endfunction

    // starts on a falling edge and returns on one 1 to 4 cycles later
    task automatic send_sample(input mag_t mag, input int gap);
        dyn_valid     = 1'b1;
        z_dynamic_abs = mag;
        @(negedge clk);
        dyn_valid = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    // low samples until both cooldown measures have surely elapsed
    task automatic send_quiet(input int unsigned min_cycles, input int min_strobes);
        int unsigned start;
        int          strobes;
        int          guard;
        start   = cycle_count;
        strobes = 0;
        guard   = 0;
        while (((cycle_count - start) < min_cycles || strobes < min_strobes) &&
               guard < 1000) begin
            send_sample(rand_mag(0, int'(th_low) - 1), int'($urandom_range(3, 0)));
            strobes++;
            guard++;
        end
        if (guard >= 1000) begin
            $display("ERROR at %0t: quiet gap between peaks never completed", $time);
            stop_run();
        end
    endtask

    // n samples at or above th_low followed by one drop sample
    task automatic send_peak(input int n, input int top);
        send_sample(rand_mag(int'(th_high), 400), int'($urandom_range(3, 0)));
        for (int i = 1; i < n; i++) begin
            send_sample(rand_mag(int'(th_low), top), int'($urandom_range(3, 0)));
        end
        // no extra gap so the pulse window is not skipped
        send_sample(rand_mag(0, int'(th_low) - 1), 0);
    endtask

    task automatic wait_for_step();
        int waited;
        waited = 0;
        while (!step_pulse && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (!step_pulse) begin
            $display("ERROR at %0t: timeout waiting for step_pulse after a valid peak",
                     $time);
            stop_run();
        end
    endtask

    // any assertion failure in the bound checker ends the run
    always @(negedge clk) begin
        if (step_detector_inst.step_detector_sva_inst.any_failed) begin
            $display("a concurrent assertion in the bound checker failed");
            stop_run();
        end
    end

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    initial begin
        int kind;
        void'($urandom(10736));
        reset          = 1'b1;
        dyn_valid      = 1'b0;
        z_dynamic_abs  = '0;
        expected_steps = '0;
        cooling        = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        repeat (60) begin
            kind = int'($urandom_range(2, 0));
            if (cooling && ($urandom_range(1, 0) == 1)) begin
                // fresh peak during the cooldown that must be ignored
                send_peak(int'($urandom_range(12, 4)), 400);
                cooling = 1'b0;
            end else begin
                send_quiet(100, 10);
                cooling = 1'b0;
                case (kind)
                    0: begin
                        send_peak(int'($urandom_range(12, 4)), 400);
                        expected_steps = expected_steps + step_count_t'(1);
                        wait_for_step();
                        cooling = 1'b1;
                    end
                    1: begin
                        send_peak(int'($urandom_range(3, 1)), 400);
                    end
                    default: begin
                        // stays below th_high after the abandon point
                        send_peak(int'($urandom_range(16, 13)), int'(th_high) - 1);
                    end
                endcase
            end
        end

        send_quiet(20, 4);
        @(negedge clk);
        if (step_count != expected_steps) begin
            $display("ERROR at %0t: step_count is %0d, expected %0d",
                     $time, step_count, expected_steps);
            stop_run();
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

//--- step_detector.f
src/step_pkg.sv
src/peak_tracker.sv
src/gap_timer.sv
src/step_qualifier.sv
src/step_detector.sv
test/step_detector_sva.sv
test/step_detector_tb.sv

//--- Makefile
TOP := step_detector_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 2>&1 | tee sim.log
	grep -q '\*\*\* TEST PASSED \*\*\*' sim.log

obj_dir/V$(TOP): step_detector.f $(wildcard src/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --assert -f step_detector.f \
		--top-module $(TOP) -Mdir obj_dir

lint:
	verilator --lint-only -Wall src/step_pkg.sv src/peak_tracker.sv \
		src/gap_timer.sv src/step_qualifier.sv src/step_detector.sv \
		--top-module step_detector

clean:
	rm -rf obj_dir sim.log
